//--- include/eth_stat_config.svh
// Statistics path build constants, included by the RTL and the testbench
`ifndef ETH_STAT_CONFIG_SVH
`define ETH_STAT_CONFIG_SVH

// Lanes sharing the statistics output stream
`define ETH_STAT_LANES 4

// Event counters in each lane
`define ETH_STAT_CNT_PER_LANE 8

// Counter and record value width
`define ETH_STAT_VAL_W 16

// Width of one per-cycle increment input
`define ETH_STAT_INC_W 2

// Cycles between update ticks
`define ETH_STAT_UPDATE_PERIOD 256

// ID of lane 0 counter 0
`define ETH_STAT_ID_BASE 0

`endif

//--- source/eth_stat_pkg.sv
// Shared types of the statistics path, imported by every RTL block and the testbench

`include "eth_stat_config.svh"

package eth_stat_pkg;

    // Global counter ID carried with each record
    typedef logic [7:0] stat_id_t;

    // Counter contents and record value
    typedef logic [`ETH_STAT_VAL_W-1:0] stat_val_t;

    // One increment input, sampled every cycle
    typedef logic [`ETH_STAT_INC_W-1:0] stat_inc_t;

    // Lane index
    typedef logic [1:0] lane_sel_t;

endpackage

//--- source/eth_stat_lane.sv
// Per-lane counter bank; instanced once per lane, emits non-zero counters on each update tick

`resetall
`timescale 1ns/1ps
`default_nettype none

`include "eth_stat_config.svh"

module eth_stat_lane #(
    parameter eth_stat_pkg::lane_sel_t LANE = '0
) (
    input  wire logic                    stat_clk,
    input  wire logic                    arst_n,

    // Event increments, one per counter
    input  wire eth_stat_pkg::stat_inc_t stat_inc [`ETH_STAT_CNT_PER_LANE],

    // Record stream towards the arbiter
    output logic                         rec_valid,
    input  wire logic                    rec_ready,
    output eth_stat_pkg::stat_id_t       rec_id,
    output eth_stat_pkg::stat_val_t      rec_value
);

    import eth_stat_pkg::*;

    localparam int CNT    = `ETH_STAT_CNT_PER_LANE;
    localparam int IDX_W  = $clog2(CNT);
    localparam int PERIOD = `ETH_STAT_UPDATE_PERIOD;
    localparam int PER_W  = $clog2(PERIOD);

    // First ID owned by this lane
    localparam stat_id_t LANE_ID_BASE = stat_id_t'(`ETH_STAT_ID_BASE + LANE * CNT);

    stat_val_t        cnt_q [CNT];
    logic [PER_W-1:0] period_cnt;
    logic             tick;
    logic             scanning;
    logic             pending;
    logic [IDX_W-1:0] scan_idx;
    logic             scan_last;
    logic             capture;
    logic             advance;

    // Update tick generator
    always_ff @(posedge stat_clk or negedge arst_n) begin
        if (!arst_n) begin
            period_cnt <= '0;
        end else if (tick) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    assign tick = period_cnt == PER_W'(PERIOD - 1);

    assign scan_last = scan_idx == IDX_W'(CNT - 1);

    // Non-zero counter moves into the record register
    assign capture = scanning && !rec_valid && (cnt_q[scan_idx] != '0);

    // Zero counters are skipped in one cycle, others move on once accepted
    assign advance = (scanning && !rec_valid && (cnt_q[scan_idx] == '0)) ||
                     (rec_valid && rec_ready);

    // Counters keep that cycle's increment when captured
    always_ff @(posedge stat_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < CNT; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < CNT; i++) begin
                if (capture && scan_idx == IDX_W'(i)) begin
                    cnt_q[i] <= stat_val_t'(stat_inc[i]);
                end else begin
                    cnt_q[i] <= cnt_q[i] + stat_val_t'(stat_inc[i]);
                end
            end
        end
    end

    // Scan sequencing and record handshake
    always_ff @(posedge stat_clk or negedge arst_n) begin
        if (!arst_n) begin
            scanning  <= 1'b0;
            pending   <= 1'b0;
            scan_idx  <= '0;
            rec_valid <= 1'b0;
        end else begin
            if (capture) begin
                rec_valid <= 1'b1;
            end else if (rec_valid && rec_ready) begin
                rec_valid <= 1'b0;
            end

            if (!scanning) begin
                if (tick) begin
                    scanning <= 1'b1;
                    scan_idx <= '0;
                end
            end else if (advance && scan_last) begin
                // Tick seen during the scan restarts it right away
                scanning <= pending || tick;
                pending  <= 1'b0;
                scan_idx <= '0;
            end else begin
                if (advance) begin
                    scan_idx <= scan_idx + 1'b1;
                end
                if (tick) begin
                    pending <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge stat_clk) begin
        if (capture) begin
            rec_value <= cnt_q[scan_idx];
        end
    end

    // Index is held while the record waits
    assign rec_id = LANE_ID_BASE + stat_id_t'(scan_idx);

endmodule

`resetall

//--- source/eth_stat_arb_mux.sv
// Round-robin merge of the lane record streams into one registered statistics stream

`resetall
`timescale 1ns/1ps
`default_nettype none

`include "eth_stat_config.svh"

module eth_stat_arb_mux (
    input  wire logic                    stat_clk,
    input  wire logic                    arst_n,

    // Lane record streams
    input  wire logic [`ETH_STAT_LANES-1:0] in_valid,
    output logic [`ETH_STAT_LANES-1:0]      in_ready,
    input  wire eth_stat_pkg::stat_id_t  in_id [`ETH_STAT_LANES],
    input  wire eth_stat_pkg::stat_val_t in_value [`ETH_STAT_LANES],

    // Merged output stream
    output logic                         m_stat_valid,
    input  wire logic                    m_stat_ready,
    output eth_stat_pkg::stat_id_t       m_stat_id,
    output eth_stat_pkg::stat_val_t      m_stat_value
);

    import eth_stat_pkg::*;

    localparam int LANES = `ETH_STAT_LANES;

    lane_sel_t last_grant;
    lane_sel_t grant_idx;
    logic      grant_valid;
    logic      load_ok;

    // Output register free now or after this cycle's transfer
    assign load_ok = !m_stat_valid || m_stat_ready;

    // Nearest requester after the last grant wins
    always_comb begin
        lane_sel_t cand;

        grant_valid = 1'b0;
        grant_idx   = last_grant;
        for (int k = LANES; k >= 1; k--) begin
            cand = last_grant + lane_sel_t'(k);
            if (in_valid[cand]) begin
                grant_valid = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    always_comb begin
        in_ready = '0;
        if (load_ok && grant_valid) begin
            in_ready[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge stat_clk or negedge arst_n) begin
        if (!arst_n) begin
            m_stat_valid <= 1'b0;
            last_grant   <= lane_sel_t'(LANES - 1);
        end else if (load_ok) begin
            m_stat_valid <= grant_valid;
            if (grant_valid) begin
                last_grant <= grant_idx;
            end
        end
    end

    // Record payload, held under back-pressure
    always_ff @(posedge stat_clk) begin
        if (load_ok && grant_valid) begin
            m_stat_id    <= in_id[grant_idx];
            m_stat_value <= in_value[grant_idx];
        end
    end

endmodule

`resetall

//--- source/eth_stat_quad.sv
// Top of the four-lane statistics path; lane counter banks merged onto one record stream

`resetall
`timescale 1ns/1ps
`default_nettype none

`include "eth_stat_config.svh"

module eth_stat_quad (
    input  wire logic                    stat_clk,
    input  wire logic                    arst_n,

    // Event increments per lane and counter
    input  wire eth_stat_pkg::stat_inc_t stat_inc [`ETH_STAT_LANES][`ETH_STAT_CNT_PER_LANE],

    // Statistics record stream
    output logic                         m_stat_valid,
    input  wire logic                    m_stat_ready,
    output eth_stat_pkg::stat_id_t       m_stat_id,
    output eth_stat_pkg::stat_val_t      m_stat_value
);

    import eth_stat_pkg::*;

    localparam int LANES = `ETH_STAT_LANES;

    wire logic [LANES-1:0] lane_valid;
    wire logic [LANES-1:0] lane_ready;
    wire stat_id_t         lane_id [LANES];
    wire stat_val_t        lane_value [LANES];

    for (genvar n = 0; n < LANES; n++) begin : g_lane
        eth_stat_lane #(
            .LANE(lane_sel_t'(n))
        ) i_eth_stat_lane (
            .stat_clk  (stat_clk),
            .arst_n    (arst_n),
            .stat_inc  (stat_inc[n]),
            .rec_valid (lane_valid[n]),
            .rec_ready (lane_ready[n]),
            .rec_id    (lane_id[n]),
            .rec_value (lane_value[n])
        );
    end

    eth_stat_arb_mux i_eth_stat_arb_mux (
        .stat_clk     (stat_clk),
        .arst_n       (arst_n),
        .in_valid     (lane_valid),
        .in_ready     (lane_ready),
        .in_id        (lane_id),
        .in_value     (lane_value),
        .m_stat_valid (m_stat_valid),
        .m_stat_ready (m_stat_ready),
        .m_stat_id    (m_stat_id),
        .m_stat_value (m_stat_value)
    );

endmodule

`resetall

//--- dv/eth_stat_quad_asserts.sv
// Output stream assertions, bound into the statistics top level for simulation
`timescale 1ns/1ps

module eth_stat_quad_asserts (
    input logic                    stat_clk,
    input logic                    arst_n,
    input logic                    m_stat_valid,
    input logic                    m_stat_ready,
    input eth_stat_pkg::stat_id_t  m_stat_id,
    input eth_stat_pkg::stat_val_t m_stat_value
);

    // Stalled record keeps valid and payload
    property hold_under_backpressure;
        @(posedge stat_clk) disable iff (!arst_n)
            m_stat_valid && !m_stat_ready |=>
                m_stat_valid && $stable(m_stat_id) && $stable(m_stat_value);
    endproperty

    // Zero counters are never emitted
    property no_zero_record;
        @(posedge stat_clk) disable iff (!arst_n)
            m_stat_valid |-> m_stat_value != '0;
    endproperty

    a_hold: assert property (hold_under_backpressure)
        else $error("output record changed while stalled");

    a_nonzero: assert property (no_zero_record)
        else $error("output record carries value zero");

endmodule

bind eth_stat_quad eth_stat_quad_asserts i_eth_stat_quad_asserts (.*);

//--- dv/eth_stat_quad_tb.sv
// Self-checking testbench for the four-lane statistics path; run with eth_stat_quad_tb as top
`timescale 1ns/1ps

`include "eth_stat_config.svh"

module eth_stat_quad_tb;

    import eth_stat_pkg::*;

    localparam int LANES           = `ETH_STAT_LANES;
    localparam int CNT             = `ETH_STAT_CNT_PER_LANE;
    localparam int TOTAL           = LANES * CNT;
    localparam int PERIOD          = `ETH_STAT_UPDATE_PERIOD;
    localparam int VAL_MAX         = (1 << `ETH_STAT_VAL_W) - 1;
    localparam int TRAFFIC_CYCLES  = 2000;
    localparam int DRAIN_LIMIT     = 6 * PERIOD;
    localparam int WATCHDOG_CYCLES = 100000;
    localparam int INC_ZERO        = 0;
    localparam int INC_RANDOM      = 1;
    localparam int INC_ONES        = 2;

    logic      stat_clk = 1'b0;
    logic      arst_n;
    stat_inc_t stat_inc [LANES][CNT];
    logic      m_stat_ready;
    logic      m_stat_valid;
    stat_id_t  m_stat_id;
    stat_val_t m_stat_value;

    logic [31:0] lfsr_state;
    int          remain [TOTAL];
    int          next_idx [LANES];
    int          idle_lane;
    logic        order_check;
    logic        valid_sample;
    int          rec_count;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          errors_at_start;
    string       test_name;

    eth_stat_quad i_eth_stat_quad (
        .stat_clk     (stat_clk),
        .arst_n       (arst_n),
        .stat_inc     (stat_inc),
        .m_stat_valid (m_stat_valid),
        .m_stat_ready (m_stat_ready),
        .m_stat_id    (m_stat_id),
        .m_stat_value (m_stat_value)
    );

    always #5 stat_clk = ~stat_clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_id(input string name, input stat_id_t got, input stat_id_t expected);
        if (got !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic check_value(input string name, input stat_val_t got, input stat_val_t expected);
        if (got !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, expected);
        end
    endtask

    // One clock: sample the output, then drive the next increments and ready
    task automatic step_cycle(input int inc_mode, input logic ready_rand);
        stat_inc_t   v;
        logic [31:0] r;
        @(posedge stat_clk);
        valid_sample = m_stat_valid;
        for (int l = 0; l < LANES; l++) begin
            for (int c = 0; c < CNT; c++) begin
                if (inc_mode == INC_RANDOM && l != idle_lane) begin
                    v = stat_inc_t'(take_bits(`ETH_STAT_INC_W));
                end else if (inc_mode == INC_ONES) begin
                    v = stat_inc_t'(1);
                end else begin
                    v = '0;
                end
                stat_inc[l][c] <= v;
                remain[l * CNT + c] += int'(v);
            end
        end
        r = ready_rand ? take_bits(1) : 32'd1;
        m_stat_ready <= r[0];
    endtask

    task automatic apply_reset();
        @(posedge stat_clk);
        arst_n <= 1'b0;
        m_stat_ready <= 1'b1;
        for (int l = 0; l < LANES; l++) begin
            for (int c = 0; c < CNT; c++) begin
                stat_inc[l][c] <= '0;
            end
        end
        for (int i = 0; i < TOTAL; i++) begin
            remain[i] = 0;
        end
        for (int i = 0; i < 3; i++) begin
            @(posedge stat_clk);
            check_flag("m_stat_valid", m_stat_valid, 1'b0);
        end
        arst_n <= 1'b1;
    endtask

    task automatic run_traffic(input logic ready_rand);
        repeat (TRAFFIC_CYCLES) begin
            step_cycle(INC_RANDOM, ready_rand);
        end
    endtask

    // Zero increments through two update periods, then until the output goes quiet
    task automatic drain_outputs();
        int cyc;
        int quiet;
        cyc   = 0;
        quiet = 0;
        while (!(cyc >= 2 * PERIOD && quiet >= 16) && cyc < DRAIN_LIMIT) begin
            step_cycle(INC_ZERO, 1'b0);
            quiet = valid_sample ? 0 : quiet + 1;
            cyc++;
        end
        if (cyc >= DRAIN_LIMIT) begin
            errors++;
            $display("Error at %0t: output did not drain within %0d cycles", $time, DRAIN_LIMIT);
        end
    endtask

    task automatic check_remainders();
        for (int i = 0; i < TOTAL; i++) begin
            if (remain[i] < 0 || remain[i] > VAL_MAX) begin
                errors++;
                $display("Error at %0t: id %0d has %0d events left over", $time, i, remain[i]);
            end else begin
                check_value($sformatf("remainder of id %0d", i), stat_val_t'(remain[i]), '0);
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        if (errors > errors_at_start) begin
            tests_failed++;
            $display("Test %s: FAIL (%0d errors)", test_name, errors - errors_at_start);
        end else begin
            $display("Test %s: ok", test_name);
        end
    endtask

    // Record monitor against the model totals
    always @(posedge stat_clk) begin
        int id_off;
        int lane;
        if (arst_n && m_stat_valid && m_stat_ready) begin
            rec_count++;
            id_off = int'(m_stat_id) - `ETH_STAT_ID_BASE;
            if (id_off < 0 || id_off >= TOTAL) begin
                errors++;
                $display("Error at %0t: record id %0d lies outside the counter range",
                         $time, m_stat_id);
            end else begin
                lane = id_off / CNT;
                if (lane == idle_lane) begin
                    errors++;
                    $display("Error at %0t: record id %0d came from idle lane %0d",
                             $time, m_stat_id, lane);
                end
                // Every counter is non-zero here, so each lane walks its IDs in order
                if (order_check) begin
                    check_id("m_stat_id", m_stat_id,
                             stat_id_t'(`ETH_STAT_ID_BASE + lane * CNT + next_idx[lane]));
                    next_idx[lane] = (next_idx[lane] + 1) % CNT;
                end
                if (remain[id_off] < int'(m_stat_value)) begin
                    errors++;
                    $display("Error at %0t: record value %0d on id %0d exceeds the %0d events driven",
                             $time, m_stat_value, m_stat_id, remain[id_off]);
                end
                remain[id_off] -= int'(m_stat_value);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge stat_clk);
        $display("Error: simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int cyc;
        int start_count;
        lfsr_state   = 32'hfd8b3d23;
        arst_n       = 1'b0;
        m_stat_ready = 1'b0;
        for (int l = 0; l < LANES; l++) begin
            for (int c = 0; c < CNT; c++) begin
                stat_inc[l][c] = '0;
            end
            next_idx[l] = 0;
        end
        for (int i = 0; i < TOTAL; i++) begin
            remain[i] = 0;
        end
        idle_lane    = -1;
        order_check  = 1'b0;
        valid_sample = 1'b0;
        rec_count    = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;

        start_test("reset_state");
        apply_reset();
        for (int i = 0; i < PERIOD; i++) begin
            step_cycle(INC_ONES, 1'b0);
            check_flag("m_stat_valid", valid_sample, 1'b0);
        end
        order_check = 1'b1;
        start_count = rec_count;
        cyc = 0;
        while (rec_count - start_count < TOTAL && cyc < 4 * TOTAL) begin
            step_cycle(INC_ONES, 1'b0);
            cyc++;
        end
        if (rec_count - start_count < TOTAL) begin
            errors++;
            $display("Error at %0t: only %0d of %0d records after the first update tick",
                     $time, rec_count - start_count, TOTAL);
        end
        order_check = 1'b0;
        drain_outputs();
        check_remainders();
        finish_test();

        start_test("totals_match");
        apply_reset();
        run_traffic(1'b0);
        drain_outputs();
        check_remainders();
        finish_test();

        start_test("back_pressure");
        apply_reset();
        run_traffic(1'b1);
        drain_outputs();
        check_remainders();
        finish_test();

        start_test("idle_lane");
        apply_reset();
        idle_lane = 2;
        run_traffic(1'b0);
        drain_outputs();
        check_remainders();
        idle_lane = -1;
        finish_test();

        start_test("zero_suppression");
        apply_reset();
        for (int i = 0; i < 2 * PERIOD; i++) begin
            step_cycle(INC_ZERO, 1'b0);
            check_flag("m_stat_valid", valid_sample, 1'b0);
        end
        finish_test();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- eth_stat_quad.f
+incdir+include
source/eth_stat_pkg.sv
source/eth_stat_lane.sv
source/eth_stat_arb_mux.sv
source/eth_stat_quad.sv
dv/eth_stat_quad_asserts.sv
dv/eth_stat_quad_tb.sv

//--- Bender.yml
package:
  name: eth_stat_quad

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/eth_stat_pkg.sv
      - source/eth_stat_lane.sv
      - source/eth_stat_arb_mux.sv
      - source/eth_stat_quad.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/eth_stat_quad_asserts.sv
      - dv/eth_stat_quad_tb.sv
